// ==== common/spi_pkg.sv ====
// SPI master shared definitions
// Word and length types, bit order and controller state encodings,
// and the longest transfer the shift register supports.

package spi_pkg;

    // Width of the parallel transmit and receive words
    parameter int SPI_WORD_WIDTH = 32;

    // Longest transfer in bits; a zero length is treated as one bit
    parameter int SPI_MAX_LENGTH = 31;

    // Parallel data word, also the shift register contents
    typedef logic [SPI_WORD_WIDTH-1:0] spi_word_t;

    // Transfer length in bits, wide enough to hold SPI_MAX_LENGTH
    typedef logic [$clog2(SPI_MAX_LENGTH + 1)-1:0] spi_length_t;

    // Order in which the word leaves on mosi and arrives on miso
    typedef enum logic {
        MSB_FIRST = 1'b0,
        LSB_FIRST = 1'b1
    } spi_order_t;

    // Transfer controller states
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        SELECT = 2'd1,
        SHIFT  = 2'd2,
        FINISH = 2'd3
    } spi_state_t;

endpackage

// ==== common/spi_shift_if.sv ====
// SPI shift register control bus
// Carries the per-transfer settings and the load, enable and capture
// commands from the transfer controller to the shift register.

`timescale 1ns/10ps

interface spi_shift_if;

    logic                 load;
    logic                 enable;
    spi_pkg::spi_order_t  order;
    spi_pkg::spi_length_t length;
    logic                 sample_level;
    logic                 capture;

    // Controller side drives every command and setting
    modport ctrl (
        output load,
        output enable,
        output order,
        output length,
        output sample_level,
        output capture
    );

    modport shreg (
        input load,
        input enable,
        input order,
        input length,
        input sample_level,
        input capture
    );

endinterface

// ==== rtl/spi_clock_gen.sv ====
// SPI serial clock generator
// Divides the system clock so that sclk toggles every HALF_PERIOD cycles
// while run is high, and flags each sample edge and each change edge.
// With run low the serial clock sits at its idle level.

`timescale 1ns/10ps

module spi_clock_gen #(
    parameter int HALF_PERIOD = 4
) (
    input  logic clock,
    input  logic reset,
    input  logic run,
    input  logic sample_level,
    output logic sclk,
    output logic sample_strobe,
    output logic change_strobe
);

    localparam int COUNT_WIDTH = $clog2(HALF_PERIOD);
    localparam logic [COUNT_WIDTH-1:0] COUNT_LAST = COUNT_WIDTH'(HALF_PERIOD - 1);

    logic [COUNT_WIDTH-1:0] count;
    logic                   sclk_q;
    logic                   edge_q;

    always_ff @(posedge clock) begin
        if (!reset) begin
            count  <= '0;
            sclk_q <= 1'b0;
            edge_q <= 1'b0;
        end else if (!run) begin
            // Park at idle so the first toggle after run rises is a sample edge
            count  <= '0;
            sclk_q <= ~sample_level;
            edge_q <= 1'b0;
        end else if (count == COUNT_LAST) begin
            count  <= '0;
            sclk_q <= ~sclk_q;
            edge_q <= 1'b1;
        end else begin
            count  <= count + 1'b1;
            edge_q <= 1'b0;
        end
    end

    // Falling run returns sclk to idle without waiting for the register
    assign sclk = run ? sclk_q : ~sample_level;

    // The new level tells which kind of edge has just happened
    assign sample_strobe = edge_q && (sclk_q == sample_level);
    assign change_strobe = edge_q && (sclk_q != sample_level);

endmodule

// ==== spi_register/spi_register.sv ====
// SPI shift register
// Loads the transmit word, presents one bit at a time on mosi and
// collects miso on each sample edge. Bit order and length come per
// transfer from the controller. At the end of a transfer the received
// bits are presented in the low bits of rx_data, the rest cleared.

`timescale 1ns/10ps

module spi_register (
    input  logic               clock,
    input  logic               reset,
    input  spi_pkg::spi_word_t tx_data,
    input  logic               miso,
    input  logic               sample_strobe,
    input  logic               change_strobe,
    spi_shift_if.shreg         shift,
    output logic               mosi,
    output spi_pkg::spi_word_t rx_data
);

    spi_pkg::spi_word_t shift_reg;
    spi_pkg::spi_word_t shift_next;
    spi_pkg::spi_word_t length_mask;
    spi_pkg::spi_length_t top_index;

    // Outgoing bit of a word for the given order and length
    function automatic logic out_bit(
        input spi_pkg::spi_word_t   word,
        input spi_pkg::spi_order_t  order,
        input spi_pkg::spi_length_t index
    );
        logic result;
        if (order == spi_pkg::LSB_FIRST) begin
            result = word[0];
        end else begin
            result = word[index];
        end
        return result;
    endfunction

    // Highest bit position in use; length is never zero here
    assign top_index = shift.length - 1'b1;

    // Received word mask, length ones in the low bits
    assign length_mask = (spi_pkg::spi_word_t'(1) << shift.length) - 1'b1;

    always_comb begin
        if (shift.order == spi_pkg::LSB_FIRST) begin
            // Insert at length-1 so the received word ends up in the low bits
            shift_next = shift_reg >> 1;
            shift_next[top_index] = miso;
        end else begin
            shift_next = {shift_reg[spi_pkg::SPI_WORD_WIDTH-2:0], miso};
        end
    end

    always_ff @(posedge clock) begin
        if (shift.load) begin
            shift_reg <= tx_data;
        end else if (shift.enable && sample_strobe) begin
            shift_reg <= shift_next;
        end
    end

    // Bits above length hold leftovers of the transmit word
    always_ff @(posedge clock) begin
        if (shift.capture) begin
            rx_data <= shift_reg & length_mask;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            mosi <= 1'b0;
        end else if (shift.load) begin
            mosi <= out_bit(tx_data, shift.order, top_index);
        end else if (!shift.enable) begin
            mosi <= 1'b0;
        end else if (change_strobe) begin
            // The register has already shifted past the bit just sampled
            mosi <= out_bit(shift_reg, shift.order, top_index);
        end
    end

endmodule

// ==== rtl/spi_controller.sv ====
// SPI transfer controller
// Latches the transfer settings on start, asserts chip select, runs the
// serial clock and counts sample edges up to the transfer length. Then it
// has the received word captured and flags completion with a done pulse.

`timescale 1ns/10ps

module spi_controller (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 start,
    input  spi_pkg::spi_length_t length,
    input  spi_pkg::spi_order_t  order,
    input  logic                 sample_level,
    input  logic                 sample_strobe,
    output logic                 busy,
    output logic                 done,
    output logic                 cs_n,
    output logic                 run,
    spi_shift_if.ctrl            shift
);

    spi_pkg::spi_state_t  state;
    spi_pkg::spi_state_t  state_next;
    spi_pkg::spi_length_t length_q;
    spi_pkg::spi_order_t  order_q;
    logic                 sample_level_q;
    spi_pkg::spi_length_t edge_count;
    logic                 last_edge;

    assign last_edge = sample_strobe && (edge_count == length_q - 1'b1);

    always_comb begin
        state_next = state;
        case (state)
            spi_pkg::IDLE: begin
                if (start) begin
                    state_next = spi_pkg::SELECT;
                end
            end
            spi_pkg::SELECT: begin
                state_next = spi_pkg::SHIFT;
            end
            spi_pkg::SHIFT: begin
                if (last_edge) begin
                    state_next = spi_pkg::FINISH;
                end
            end
            default: begin
                state_next = spi_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state          <= spi_pkg::IDLE;
            length_q       <= spi_pkg::spi_length_t'(1);
            order_q        <= spi_pkg::MSB_FIRST;
            sample_level_q <= 1'b1;
            edge_count     <= '0;
            done           <= 1'b0;
        end else begin
            state <= state_next;
            // Done follows FINISH, when rx_data has just been captured
            done  <= (state == spi_pkg::FINISH);
            if (state == spi_pkg::IDLE && start) begin
                // A zero length runs as a single bit
                if (length == '0) begin
                    length_q <= spi_pkg::spi_length_t'(1);
                end else begin
                    length_q <= length;
                end
                order_q        <= order;
                sample_level_q <= sample_level;
                edge_count     <= '0;
            end else if (state == spi_pkg::SHIFT && sample_strobe) begin
                edge_count <= edge_count + 1'b1;
            end
        end
    end

    assign busy = (state != spi_pkg::IDLE);
    assign cs_n = !(state == spi_pkg::SELECT || state == spi_pkg::SHIFT);
    assign run  = (state == spi_pkg::SHIFT);

    // SELECT lasts one cycle, so load is a single pulse
    assign shift.load         = (state == spi_pkg::SELECT);
    assign shift.enable       = (state == spi_pkg::SHIFT);
    assign shift.capture      = (state == spi_pkg::FINISH);
    assign shift.order        = order_q;
    assign shift.length       = length_q;
    assign shift.sample_level = sample_level_q;

endmodule

// ==== rtl/spi_master.sv ====
// SPI master top level
// Single chip select master. A start pulse sends tx_data on mosi and
// collects miso into rx_data. Bit order, transfer length and sample
// edge are taken with each start. done pulses when rx_data is valid.

`timescale 1ns/10ps

module spi_master #(
    parameter int HALF_PERIOD = 4
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 start,
    input  spi_pkg::spi_word_t   tx_data,
    input  spi_pkg::spi_length_t length,
    input  spi_pkg::spi_order_t  order,
    input  logic                 sample_level,
    input  logic                 miso,
    output logic                 busy,
    output logic                 done,
    output spi_pkg::spi_word_t   rx_data,
    output logic                 sclk,
    output logic                 mosi,
    output logic                 cs_n
);

    logic run;
    logic sample_strobe;
    logic change_strobe;

    spi_shift_if shift_bus ();

    spi_controller u_controller (
        .clock         (clock),
        .reset         (reset),
        .start         (start),
        .length        (length),
        .order         (order),
        .sample_level  (sample_level),
        .sample_strobe (sample_strobe),
        .busy          (busy),
        .done          (done),
        .cs_n          (cs_n),
        .run           (run),
        .shift         (shift_bus.ctrl)
    );

    // The clock follows the latched edge setting, not the live input
    spi_clock_gen #(
        .HALF_PERIOD (HALF_PERIOD)
    ) u_clock_gen (
        .clock         (clock),
        .reset         (reset),
        .run           (run),
        .sample_level  (shift_bus.sample_level),
        .sclk          (sclk),
        .sample_strobe (sample_strobe),
        .change_strobe (change_strobe)
    );

    spi_register u_register (
        .clock         (clock),
        .reset         (reset),
        .tx_data       (tx_data),
        .miso          (miso),
        .sample_strobe (sample_strobe),
        .change_strobe (change_strobe),
        .shift         (shift_bus.shreg),
        .mosi          (mosi),
        .rx_data       (rx_data)
    );

endmodule

// ==== sim/spi_master_checker.sv ====
// SPI master protocol checker
// Bound into the SPI master top level. Watches chip select against busy,
// the done pulse width, the sclk idle level and when mosi may move.

`timescale 1ns/10ps

module spi_master_checker (
    input logic clock,
    input logic reset,
    input logic start,
    input logic sample_level,
    input logic busy,
    input logic done,
    input logic cs_n,
    input logic sclk,
    input logic mosi,
    input logic run,
    input logic change_strobe
);

    // Sample level as taken by an accepted start, kept apart from the DUT copy
    logic level_q;

    always_ff @(posedge clock) begin
        if (!reset) begin
            level_q <= 1'b1;
        end else if (start && !busy) begin
            level_q <= sample_level;
        end
    end

    cs_n_follows_start: assert property (@(posedge clock) disable iff (!reset)
        start && !busy |=> busy && !cs_n)
        else $error("chip select did not go active one cycle after start");

    done_single: assert property (@(posedge clock) disable iff (!reset) done |=> !done)
        else $error("done stayed high for more than one cycle");

    // Idle level is the inverse of the sample level taken at start
    sclk_parked: assert property (@(posedge clock) disable iff (!reset)
        cs_n |-> sclk == !level_q)
        else $error("sclk left its idle level while cs_n is high");

    // While the clock runs, mosi moves only in the cycle after a change edge
    mosi_steady: assert property (@(posedge clock) disable iff (!reset)
        run && $past(run) && !$stable(mosi) |-> $past(change_strobe))
        else $error("mosi changed without a change edge");

endmodule

bind spi_master spi_master_checker u_checker (
    .clock         (clock),
    .reset         (reset),
    .start         (start),
    .sample_level  (sample_level),
    .busy          (busy),
    .done          (done),
    .cs_n          (cs_n),
    .sclk          (sclk),
    .mosi          (mosi),
    .run           (run),
    .change_strobe (change_strobe)
);

// ==== sim/spi_master_tb.sv ====
// SPI master testbench
// Runs the transfers listed in sim/spi_vectors.txt against the SPI master.
// A small SPI slave model on the serial pins checks what the DUT sends.
// The word seen on mosi, rx_data and the sclk edge counts are compared
// with the expected values from the vector file.

`timescale 1ns/10ps

module spi_master_tb;

    localparam int HALF_PERIOD  = 4;
    localparam int FIELDS       = 7;
    localparam int MAX_VECTORS  = 64;
    localparam int DONE_TIMEOUT = 4 * 32 * HALF_PERIOD;

    logic                 clock;
    logic                 reset;
    logic                 start;
    spi_pkg::spi_word_t   tx_data;
    spi_pkg::spi_length_t length;
    spi_pkg::spi_order_t  order;
    logic                 sample_level;
    logic                 miso;
    logic                 busy;
    logic                 done;
    spi_pkg::spi_word_t   rx_data;
    logic                 sclk;
    logic                 mosi;
    logic                 cs_n;

    // One vector is FIELDS consecutive words
    logic [31:0] vector_mem [0:MAX_VECTORS*FIELDS-1];

    // Settings the slave model uses for the current transfer
    spi_pkg::spi_word_t  reply_word;
    spi_pkg::spi_order_t slave_order;
    logic                slave_level;
    int                  slave_length;

    // What the slave saw in the last chip select window
    spi_pkg::spi_word_t observed;
    int                 sample_edges;
    int                 transitions;

    int errors;

    spi_master #(
        .HALF_PERIOD (HALF_PERIOD)
    ) uut (
        .clock        (clock),
        .reset        (reset),
        .start        (start),
        .tx_data      (tx_data),
        .length       (length),
        .order        (order),
        .sample_level (sample_level),
        .miso         (miso),
        .busy         (busy),
        .done         (done),
        .rx_data      (rx_data),
        .sclk         (sclk),
        .mosi         (mosi),
        .cs_n         (cs_n)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Reply bit number index in transmit order, zero past the end
    function automatic logic reply_bit(input int index);
        logic result;
        if (index >= slave_length) begin
            result = 1'b0;
        end else if (slave_order == spi_pkg::LSB_FIRST) begin
            result = reply_word[index];
        end else begin
            result = reply_word[slave_length-1-index];
        end
        return result;
    endfunction

    // Slave model, looks at the serial pins on the falling system clock edge
    initial begin
        logic sclk_prev;
        logic cs_n_prev;
        int   next_bit;
        miso         = 1'b0;
        sclk_prev    = 1'b0;
        cs_n_prev    = 1'b1;
        next_bit     = 0;
        observed     = '0;
        sample_edges = 0;
        transitions  = 0;
        forever begin
            @(negedge clock);
            if (!cs_n_prev && sclk !== sclk_prev) begin
                transitions++;
            end
            if (!cs_n && cs_n_prev) begin
                observed     = '0;
                sample_edges = 0;
                transitions  = 0;
                next_bit     = 0;
                miso         = reply_bit(0);
            end else if (!cs_n && sclk !== sclk_prev) begin
                if (sclk == slave_level) begin
                    if (slave_order == spi_pkg::LSB_FIRST) begin
                        observed = observed | (spi_pkg::spi_word_t'(mosi) << sample_edges);
                    end else begin
                        observed = {observed[30:0], mosi};
                    end
                    sample_edges++;
                end else begin
                    next_bit++;
                    miso = reply_bit(next_bit);
                end
            end
            sclk_prev = sclk;
            cs_n_prev = cs_n;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        assert (actual === expected) else begin
            errors++;
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    // With stray set, a second start arrives while the transfer is in SHIFT
    task automatic run_transfer(input int index, input bit stray, output bit arrived);
        int base;
        int cycle;
        int bits;
        base = index * FIELDS;
        bits = (vector_mem[base+2] == 32'd0) ? 1 : int'(vector_mem[base+2]);
        @(negedge clock);
        order        = spi_pkg::spi_order_t'(vector_mem[base][0]);
        sample_level = vector_mem[base+1][0];
        length       = spi_pkg::spi_length_t'(vector_mem[base+2]);
        tx_data      = vector_mem[base+3];
        reply_word   = vector_mem[base+4];
        slave_order  = order;
        slave_level  = sample_level;
        slave_length = bits;
        start        = 1'b1;
        arrived      = 1'b0;
        for (cycle = 0; cycle < DONE_TIMEOUT && !arrived; cycle++) begin
            @(negedge clock);
            start = stray && (cycle == 2);
            if (start) begin
                tx_data      = ~tx_data;
                order        = spi_pkg::spi_order_t'(~order);
                length       = ~length;
                sample_level = ~sample_level;
            end
            arrived = done;
        end
        assert (arrived) else begin
            errors++;
            $display("Timeout on vector %0d: done never arrived", index);
        end
        if (arrived) begin
            check_value("mosi word", observed, vector_mem[base+5]);
            check_value("rx_data", rx_data, vector_mem[base+6]);
            check_value("sample edges", 32'(sample_edges), 32'(bits));
            check_value("sclk transitions", 32'(transitions), 32'(2 * bits));
            check_value("busy", 32'(busy), 32'd0);
            check_value("sclk", 32'(sclk), 32'(!slave_level));
        end
    endtask

    initial begin
        int vector_count;
        bit arrived;
        errors       = 0;
        reset        = 1'b0;
        start        = 1'b0;
        tx_data      = '0;
        length       = '0;
        order        = spi_pkg::MSB_FIRST;
        sample_level = 1'b1;
        reply_word   = '0;
        slave_order  = spi_pkg::MSB_FIRST;
        slave_level  = 1'b1;
        slave_length = 1;
        // Filler words past the end of the file are never a valid order field
        for (int i = 0; i < MAX_VECTORS * FIELDS; i++) begin
            vector_mem[i] = {16'hbad0, 16'(i)};
        end
        $readmemh("sim/spi_vectors.txt", vector_mem);
        repeat (16) @(negedge clock);
        reset = 1'b1;
        @(negedge clock);
        check_value("busy", 32'(busy), 32'd0);
        check_value("done", 32'(done), 32'd0);
        check_value("cs_n", 32'(cs_n), 32'd1);
        check_value("sclk", 32'(sclk), 32'd0);
        check_value("mosi", 32'(mosi), 32'd0);
        vector_count = 0;
        while (vector_count < MAX_VECTORS && vector_mem[vector_count*FIELDS] <= 32'd1) begin
            vector_count++;
        end
        assert (vector_count > 0) else begin
            errors++;
            $display("No vectors could be read from sim/spi_vectors.txt");
        end
        arrived = 1'b1;
        for (int v = 0; v < vector_count && arrived; v++) begin
            run_transfer(v, (v % 4) == 3, arrived);
        end
        $display("Vectors: %0d, error count: %0d", vector_count, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== sim/spi_vectors.txt ====
// order sample_level length tx_data slave_reply expected_mosi_word expected_rx
// order 0 is MSB first and 1 is LSB first, every field in hex
0 1 08 123456A5 CAFE003C 000000A5 0000003C
0 0 08 FFFFFF5A 12345681 0000005A 00000081
0 1 10 89ABCDEF 0F1E2D3C 0000CDEF 00002D3C
0 0 10 A5A5C3E1 5A5A1234 0000C3E1 00001234
0 1 1F DEADBEEF 76543210 5EADBEEF 76543210
0 0 1F 80000001 FFFFFFFF 00000001 7FFFFFFF
1 1 01 FFFFFFFE 00000001 00000000 00000001
1 0 01 00000001 FFFFFFFE 00000001 00000000
1 1 05 0000003B 00000016 0000001B 00000016
1 0 05 ABCDEF12 12345679 00000012 00000019
1 1 08 0000C35A 000000A7 0000005A 000000A7
1 0 10 1234F00F 5678AAAA 0000F00F 0000AAAA
1 1 1F FFFFFFFF 55555555 7FFFFFFF 55555555
1 0 1F 13579BDF 2468ACE0 13579BDF 2468ACE0
0 1 00 00000001 00000000 00000001 00000000
1 0 03 00000006 00000005 00000006 00000005
0 1 0C 00000ABC 00000321 00000ABC 00000321
0 0 14 000F0F0F 0009876A 000F0F0F 0009876A
1 1 18 00C0FFEE 00BEEF00 00C0FFEE 00BEEF00
0 0 02 00000002 00000001 00000002 00000001

// ==== src.f ====
common/spi_pkg.sv
common/spi_shift_if.sv
rtl/spi_clock_gen.sv
spi_register/spi_register.sv
rtl/spi_controller.sv
rtl/spi_master.sv
sim/spi_master_checker.sv
sim/spi_master_tb.sv

// ==== Makefile ====
# Verilator build and run of the SPI master testbench

TOP = spi_master_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f src.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir
